// File: flist.f
verilog/isa_pkg.sv
verilog/mem_pkg.sv
verilog/wb_mem_classify.sv
verilog/wb_redirect.sv
verilog/wb_commit_reg.sv
verilog/wb_top.sv
verification/wb_chk.sv
verification/tb_wb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the writeback stage testbench from the project root

rm -f sim.log

verilator --binary --assert --top-module tb_wb_top -f flist.f -o sim_wb > build.log 2>&1 \
    && ./obj_dir/sim_wb > sim.log 2>&1 \
    || echo "build or simulation did not complete, see build.log and sim.log"

grep -q "^Regression passed$" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: verification/wb_trace.txt
// flags: stall flush valid wreg excp refetch last mllwe mllval llbit llwe llval (one nibble each)
// then pc aluop load_addr store_addr tlb_tag | expect: ld st cnt fflush bend dflush, ld_pa, st_pa
001100000000 1c000000 20 00401234 00000000 8a001 100000 8a001234 8a001000
001100000000 1c000004 21 00402abc 00000010 12345 100000 12345abc 12345010
001100100000 1c000008 22 7fff0ffe 00000000 fffff 100010 fffffffe fffff000
001100000000 1c00000c 23 a0000001 00000000 00000 100000 00000001 00000000
001100000000 1c000010 24 12345678 00000000 abcde 100000 abcde678 abcde000
001100011000 1c000014 25 00001ff0 00000000 00100 100000 00100ff0 00100000
001000000000 1c000018 28 00000000 0040a001 0c0de 010000 0c0de000 0c0de001
001000000000 1c00001c 29 00000000 0040b002 11111 010000 11111000 11111002
001000100000 1c000020 2a 00000000 deadbeef 22222 010010 22222000 22222eef
001100000011 1c000024 2b 00000000 00005554 33333 010000 33333000 33333554
001100000110 1c000028 2b 00000000 00005558 44444 000000 44444000 44444558
001100000100 1c00002c 2b 00000000 0000555c 55555 010000 55555000 5555555c
001100000000 1c000030 2b 00000000 00005560 66666 000000 66666000 66666560
001100000000 1c000034 30 00000000 00000000 77777 001000 77777000 77777000
001100000000 1c000038 31 00000000 00000000 77777 001000 77777000 77777000
001100000000 1c00003c 32 00000000 00000000 77777 001000 77777000 77777000
001010000000 1c000040 00 00000000 00000000 00000 000111 00000000 00000000
001001000000 1c000044 00 00000000 00000000 00000 000100 00000000 00000000
101100000000 1c000048 24 00000abc 00000000 99999 100000 99999abc 99999000
011010000000 1c00004c 00 00000000 00000000 00000 000111 00000000 00000000
111100000000 1c000050 2a 00000000 00001234 0abcd 010000 0abcd000 0abcd234
000010000000 1c000054 00 00000000 00000000 00000 000110 00000000 00000000
001100000000 1c000058 10 00000000 00000000 00000 000000 00000000 00000000
001100000000 1c00005c 24 0000f00d 00000000 fedcb 100000 fedcb00d fedcb000

// File: verification/tb_wb_top.sv
module tb_wb_top;

    localparam int ROWS = 24;
    localparam int COLS = 9;

    logic        clk;
    logic        rst_n_i, stall_i, flush_i, valid_i, wreg_i, excp_i;
    logic        need_refetch_i, is_last_in_block_i, mem_llbit_we_i, mem_llbit_value_i;
    logic        llbit_i, llbit_we_i, llbit_value_i;
    logic [31:0] pc_i, instr_i, wdata_i, load_addr_i, store_addr_i, store_data_i;
    logic [7:0]  aluop_i;
    logic [4:0]  waddr_i;
    logic [19:0] tlb_tag_i;
    logic [15:0] excp_num_i;
    logic [2:0]  ftq_id_i;
    logic [63:0] timer_i;

    // DUT outputs
    logic        fwd_we_o, dcache_flush_o, commit_valid_o, commit_we_o;
    logic        commit_llbit_we_o, commit_llbit_value_o, commit_excp_o;
    logic        commit_fetch_flush_o, commit_block_end_o;
    logic        commit_ld_en_o, commit_st_en_o, commit_cnt_o;
    logic [4:0]  fwd_waddr_o, commit_waddr_o;
    logic [31:0] fwd_wdata_o, dcache_flush_pc_o, commit_pc_o, commit_instr_o;
    logic [31:0] commit_wdata_o, commit_st_data_o;
    logic [31:0] commit_ld_paddr_o, commit_ld_vaddr_o, commit_st_paddr_o, commit_st_vaddr_o;
    logic [7:0]  commit_aluop_o;
    logic [15:0] commit_excp_num_o;
    logic [2:0]  ftq_id_o;
    logic [63:0] commit_timer_o;

    logic [63:0] trace_mem [0:ROWS*COLS-1];

    // Expected commit record for the row driven last
    logic        e_valid, e_we, e_llwe, e_llval, e_excp, e_ffl, e_bend, e_ld, e_st, e_cnt;
    logic [31:0] e_pc, e_instr, e_wdata, e_sdata, e_lpa, e_lva, e_spa, e_sva;
    logic [7:0]  e_op;
    logic [4:0]  e_waddr;
    logic [15:0] e_enum;
    logic [2:0]  e_ftq;
    logic [63:0] e_timer;
    logic        cur_dflush;
    int          wait_cnt;

    wb_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic nibble_flag(input logic [63:0] w, input int k, input int n);
        return w[4*(n-1-k)];
    endfunction

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_row(input int i);
        logic [63:0] f;
        logic [63:0] e;
        logic        bub;
        int          b;
        b = i * COLS;
        f = trace_mem[b];
        e = trace_mem[b+6];
        stall_i            = nibble_flag(f, 0, 12);
        flush_i            = nibble_flag(f, 1, 12);
        valid_i            = nibble_flag(f, 2, 12);
        wreg_i             = nibble_flag(f, 3, 12);
        excp_i             = nibble_flag(f, 4, 12);
        need_refetch_i     = nibble_flag(f, 5, 12);
        is_last_in_block_i = nibble_flag(f, 6, 12);
        mem_llbit_we_i     = nibble_flag(f, 7, 12);
        mem_llbit_value_i  = nibble_flag(f, 8, 12);
        llbit_i            = nibble_flag(f, 9, 12);
        llbit_we_i         = nibble_flag(f, 10, 12);
        llbit_value_i      = nibble_flag(f, 11, 12);
        pc_i         = trace_mem[b+1][31:0];
        aluop_i      = trace_mem[b+2][7:0];
        load_addr_i  = trace_mem[b+3][31:0];
        store_addr_i = trace_mem[b+4][31:0];
        tlb_tag_i    = trace_mem[b+5][19:0];
        instr_i      = $urandom;
        wdata_i      = $urandom;
        store_data_i = $urandom;
        waddr_i      = 5'($urandom);
        excp_num_i   = 16'($urandom);
        ftq_id_i     = 3'($urandom);
        timer_i      = {$urandom, $urandom};
        cur_dflush   = nibble_flag(e, 5, 6);
        // A bubble edge loads an all-zero record
        bub     = stall_i || flush_i;
        e_valid = bub ? 1'b0 : valid_i;
        e_we    = bub ? 1'b0 : wreg_i;
        e_llwe  = bub ? 1'b0 : mem_llbit_we_i;
        e_llval = bub ? 1'b0 : mem_llbit_value_i;
        e_excp  = bub ? 1'b0 : excp_i;
        e_ld    = bub ? 1'b0 : nibble_flag(e, 0, 6);
        e_st    = bub ? 1'b0 : nibble_flag(e, 1, 6);
        e_cnt   = bub ? 1'b0 : nibble_flag(e, 2, 6);
        e_ffl   = bub ? 1'b0 : nibble_flag(e, 3, 6);
        e_bend  = bub ? 1'b0 : nibble_flag(e, 4, 6);
        e_pc    = bub ? '0 : pc_i;
        e_instr = bub ? '0 : instr_i;
        e_wdata = bub ? '0 : wdata_i;
        e_sdata = bub ? '0 : store_data_i;
        e_op    = bub ? '0 : aluop_i;
        e_waddr = bub ? '0 : waddr_i;
        e_enum  = bub ? '0 : excp_num_i;
        e_ftq   = bub ? '0 : ftq_id_i;
        e_timer = bub ? '0 : timer_i;
        e_lva   = bub ? '0 : load_addr_i;
        e_sva   = bub ? '0 : store_addr_i;
        e_lpa   = bub ? '0 : trace_mem[b+7][31:0];
        e_spa   = bub ? '0 : trace_mem[b+8][31:0];
    endtask

    task automatic probe_forward();
        compare_value("fwd_we_o", 64'(fwd_we_o), 64'(wreg_i));
        compare_value("fwd_waddr_o", 64'(fwd_waddr_o), 64'(waddr_i));
        compare_value("fwd_wdata_o", 64'(fwd_wdata_o), 64'(wdata_i));
        compare_value("dcache_flush_o", 64'(dcache_flush_o), 64'(cur_dflush));
        compare_value("dcache_flush_pc_o", 64'(dcache_flush_pc_o), 64'(pc_i));
    endtask

    task automatic review_commit();
        compare_value("commit_valid_o", 64'(commit_valid_o), 64'(e_valid));
        compare_value("commit_pc_o", 64'(commit_pc_o), 64'(e_pc));
        compare_value("commit_instr_o", 64'(commit_instr_o), 64'(e_instr));
        compare_value("commit_wdata_o", 64'(commit_wdata_o), 64'(e_wdata));
        compare_value("commit_st_data_o", 64'(commit_st_data_o), 64'(e_sdata));
        compare_value("commit_aluop_o", 64'(commit_aluop_o), 64'(e_op));
        compare_value("commit_we_o", 64'(commit_we_o), 64'(e_we));
        compare_value("commit_waddr_o", 64'(commit_waddr_o), 64'(e_waddr));
        compare_value("commit_llbit_we_o", 64'(commit_llbit_we_o), 64'(e_llwe));
        compare_value("commit_llbit_value_o", 64'(commit_llbit_value_o), 64'(e_llval));
        compare_value("commit_excp_o", 64'(commit_excp_o), 64'(e_excp));
        compare_value("commit_excp_num_o", 64'(commit_excp_num_o), 64'(e_enum));
        compare_value("commit_fetch_flush_o", 64'(commit_fetch_flush_o), 64'(e_ffl));
        compare_value("commit_block_end_o", 64'(commit_block_end_o), 64'(e_bend));
        compare_value("commit_ld_en_o", 64'(commit_ld_en_o), 64'(e_ld));
        compare_value("commit_st_en_o", 64'(commit_st_en_o), 64'(e_st));
        compare_value("commit_cnt_o", 64'(commit_cnt_o), 64'(e_cnt));
        compare_value("commit_ld_paddr_o", 64'(commit_ld_paddr_o), 64'(e_lpa));
        compare_value("commit_ld_vaddr_o", 64'(commit_ld_vaddr_o), 64'(e_lva));
        compare_value("commit_st_paddr_o", 64'(commit_st_paddr_o), 64'(e_spa));
        compare_value("commit_st_vaddr_o", 64'(commit_st_vaddr_o), 64'(e_sva));
        compare_value("commit_timer_o", commit_timer_o, e_timer);
        compare_value("ftq_id_o", 64'(ftq_id_o), 64'(e_ftq));
    endtask

    initial begin
        {rst_n_i, stall_i, flush_i, valid_i, wreg_i, excp_i} = '0;
        {need_refetch_i, is_last_in_block_i, mem_llbit_we_i, mem_llbit_value_i} = '0;
        {llbit_i, llbit_we_i, llbit_value_i} = '0;
        {pc_i, instr_i, wdata_i, load_addr_i, store_addr_i, store_data_i} = '0;
        {aluop_i, waddr_i, tlb_tag_i, excp_num_i, ftq_id_i, timer_i} = '0;
        cur_dflush = 1'b0;
        void'($urandom(66662));
        $readmemh("verification/wb_trace.txt", trace_mem);

        repeat (8) @(posedge clk);
        #2 rst_n_i = 1'b1;

        wait_cnt = 0;
        while (rst_n_i !== 1'b1 || commit_valid_o !== 1'b0) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 16) begin
                $display("Timeout: DUT did not leave reset");
                $display("Regression failed");
                $fatal(1, "reset timeout");
            end
        end

        for (int i = 0; i <= ROWS; i++) begin
            @(posedge clk);
            #2;
            if (i > 0) begin
                review_commit();
            end
            if (i < ROWS) begin
                drive_row(i);
                #1;
                probe_forward();
            end
        end

        if (UUT.u_commit_reg.u_chk.fail_count != 0) begin
            $display("Bound assertions failed %0d times", UUT.u_commit_reg.u_chk.fail_count);
            $display("Regression failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: verification/wb_chk.sv
module wb_chk (
    input logic clk,
    input logic rst_n_i,
    input logic stall_i,
    input logic flush_i,
    input logic valid_i,
    input logic excp_i,
    input logic commit_valid_o,
    input logic commit_we_o,
    input logic commit_excp_o,
    input logic commit_fetch_flush_o
);

    // Number of assertion failures so far
    int fail_count = 0;

    // A stalled or flushed slot commits nothing
    bubble_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stall_i || flush_i) |=> !commit_valid_o)
        else begin
            fail_count++;
            $error("commit_valid_o high after a stall or flush cycle");
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |-> !(commit_valid_o || commit_we_o || commit_excp_o || commit_fetch_flush_o))
        else begin
            fail_count++;
            $error("commit outputs active during reset");
        end

    // Trap redirects the frontend one cycle later
    excp_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_i && excp_i && !stall_i && !flush_i) |=> (commit_fetch_flush_o && commit_excp_o))
        else begin
            fail_count++;
            $error("excepting instruction did not commit a fetch flush");
        end

endmodule

bind wb_commit_reg wb_chk u_chk (.*);

// File: verilog/wb_top.sv
module wb_top (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           stall_i,
    input  logic                           flush_i,

    // Retiring instruction from the second memory stage
    input  logic                           valid_i,
    input  logic [isa_pkg::REG_W-1:0]      pc_i,
    input  logic [isa_pkg::REG_W-1:0]      instr_i,
    input  logic [isa_pkg::ALUOP_W-1:0]    aluop_i,
    input  logic                           wreg_i,
    input  logic [isa_pkg::RADDR_W-1:0]    waddr_i,
    input  logic [isa_pkg::REG_W-1:0]      wdata_i,
    input  logic [mem_pkg::VADDR_W-1:0]    load_addr_i,
    input  logic [mem_pkg::VADDR_W-1:0]    store_addr_i,
    input  logic [isa_pkg::REG_W-1:0]      store_data_i,
    input  logic [mem_pkg::PTAG_W-1:0]     tlb_tag_i,
    input  logic                           excp_i,
    input  logic [isa_pkg::EXCP_NUM_W-1:0] excp_num_i,
    input  logic                           need_refetch_i,
    input  logic                           is_last_in_block_i,
    input  logic [isa_pkg::FTQ_ID_W-1:0]   ftq_id_i,
    input  logic [isa_pkg::TIMER_W-1:0]    timer_i,
    input  logic                           mem_llbit_we_i,
    input  logic                           mem_llbit_value_i,

    // LL bit from the CSR file
    input  logic                           llbit_i,
    input  logic                           llbit_we_i,
    input  logic                           llbit_value_i,

    // Forward to dispatch
    output logic                           fwd_we_o,
    output logic [isa_pkg::RADDR_W-1:0]    fwd_waddr_o,
    output logic [isa_pkg::REG_W-1:0]      fwd_wdata_o,

    output logic                           dcache_flush_o,
    output logic [isa_pkg::REG_W-1:0]      dcache_flush_pc_o,

    // Commit record for retire and difftest
    output logic                           commit_valid_o,
    output logic [isa_pkg::REG_W-1:0]      commit_pc_o,
    output logic [isa_pkg::REG_W-1:0]      commit_instr_o,
    output logic [isa_pkg::REG_W-1:0]      commit_wdata_o,
    output logic [isa_pkg::REG_W-1:0]      commit_st_data_o,
    output logic [isa_pkg::ALUOP_W-1:0]    commit_aluop_o,
    output logic                           commit_we_o,
    output logic [isa_pkg::RADDR_W-1:0]    commit_waddr_o,
    output logic                           commit_llbit_we_o,
    output logic                           commit_llbit_value_o,
    output logic                           commit_excp_o,
    output logic [isa_pkg::EXCP_NUM_W-1:0] commit_excp_num_o,
    output logic                           commit_fetch_flush_o,
    output logic                           commit_block_end_o,
    output logic                           commit_ld_en_o,
    output logic                           commit_st_en_o,
    output logic                           commit_cnt_o,
    output logic [mem_pkg::VADDR_W-1:0]    commit_ld_paddr_o,
    output logic [mem_pkg::VADDR_W-1:0]    commit_ld_vaddr_o,
    output logic [mem_pkg::VADDR_W-1:0]    commit_st_paddr_o,
    output logic [mem_pkg::VADDR_W-1:0]    commit_st_vaddr_o,
    output logic [isa_pkg::TIMER_W-1:0]    commit_timer_o,
    output logic [isa_pkg::FTQ_ID_W-1:0]   ftq_id_o
);
    import mem_pkg::*;

    logic               ld_en;
    logic               st_en;
    logic               cnt_inst;
    logic [VADDR_W-1:0] ld_paddr;
    logic [VADDR_W-1:0] st_paddr;
    logic               fetch_flush;
    logic               block_end;

    // Bypass to dispatch, not held back by stall
    assign fwd_we_o    = wreg_i;
    assign fwd_waddr_o = waddr_i;
    assign fwd_wdata_o = wdata_i;

    wb_mem_classify u_mem_classify (
        .ld_en_o    (ld_en),
        .st_en_o    (st_en),
        .cnt_inst_o (cnt_inst),
        .ld_paddr_o (ld_paddr),
        .st_paddr_o (st_paddr),
        .*
    );

    wb_redirect u_redirect (
        .fetch_flush_o (fetch_flush),
        .block_end_o   (block_end),
        .*
    );

    wb_commit_reg u_commit_reg (
        .ld_en_i       (ld_en),
        .st_en_i       (st_en),
        .cnt_inst_i    (cnt_inst),
        .ld_paddr_i    (ld_paddr),
        .st_paddr_i    (st_paddr),
        .fetch_flush_i (fetch_flush),
        .block_end_i   (block_end),
        .*
    );

endmodule

// File: verilog/wb_commit_reg.sv
module wb_commit_reg (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           stall_i,
    input  logic                           flush_i,

    input  logic                           valid_i,
    input  logic [isa_pkg::REG_W-1:0]      pc_i,
    input  logic [isa_pkg::REG_W-1:0]      instr_i,
    input  logic [isa_pkg::REG_W-1:0]      wdata_i,
    input  logic [isa_pkg::REG_W-1:0]      store_data_i,
    input  logic [isa_pkg::ALUOP_W-1:0]    aluop_i,
    input  logic                           wreg_i,
    input  logic [isa_pkg::RADDR_W-1:0]    waddr_i,
    input  logic [isa_pkg::EXCP_NUM_W-1:0] excp_num_i,
    input  logic [isa_pkg::FTQ_ID_W-1:0]   ftq_id_i,
    input  logic [isa_pkg::TIMER_W-1:0]    timer_i,
    input  logic                           excp_i,
    input  logic                           mem_llbit_we_i,
    input  logic                           mem_llbit_value_i,
    input  logic [mem_pkg::VADDR_W-1:0]    load_addr_i,
    input  logic [mem_pkg::VADDR_W-1:0]    store_addr_i,

    input  logic                           ld_en_i,
    input  logic                           st_en_i,
    input  logic                           cnt_inst_i,
    input  logic [mem_pkg::VADDR_W-1:0]    ld_paddr_i,
    input  logic [mem_pkg::VADDR_W-1:0]    st_paddr_i,
    input  logic                           fetch_flush_i,
    input  logic                           block_end_i,

    output logic                           commit_valid_o,
    output logic [isa_pkg::REG_W-1:0]      commit_pc_o,
    output logic [isa_pkg::REG_W-1:0]      commit_instr_o,
    output logic [isa_pkg::REG_W-1:0]      commit_wdata_o,
    output logic [isa_pkg::REG_W-1:0]      commit_st_data_o,
    output logic [isa_pkg::ALUOP_W-1:0]    commit_aluop_o,
    output logic                           commit_we_o,
    output logic [isa_pkg::RADDR_W-1:0]    commit_waddr_o,
    output logic                           commit_llbit_we_o,
    output logic                           commit_llbit_value_o,
    output logic                           commit_excp_o,
    output logic [isa_pkg::EXCP_NUM_W-1:0] commit_excp_num_o,
    output logic                           commit_fetch_flush_o,
    output logic                           commit_block_end_o,
    output logic                           commit_ld_en_o,
    output logic                           commit_st_en_o,
    output logic                           commit_cnt_o,
    output logic [mem_pkg::VADDR_W-1:0]    commit_ld_paddr_o,
    output logic [mem_pkg::VADDR_W-1:0]    commit_ld_vaddr_o,
    output logic [mem_pkg::VADDR_W-1:0]    commit_st_paddr_o,
    output logic [mem_pkg::VADDR_W-1:0]    commit_st_vaddr_o,
    output logic [isa_pkg::TIMER_W-1:0]    commit_timer_o,
    output logic [isa_pkg::FTQ_ID_W-1:0]   ftq_id_o
);

    // Stall and flush both turn the slot into a bubble
    logic bubble;

    assign bubble = stall_i || flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i || bubble) begin
            commit_valid_o       <= 1'b0;
            commit_pc_o          <= '0;
            commit_instr_o       <= '0;
            commit_wdata_o       <= '0;
            commit_st_data_o     <= '0;
            commit_aluop_o       <= '0;
            commit_we_o          <= 1'b0;
            commit_waddr_o       <= '0;
            commit_llbit_we_o    <= 1'b0;
            commit_llbit_value_o <= 1'b0;
            commit_excp_o        <= 1'b0;
            commit_excp_num_o    <= '0;
            commit_fetch_flush_o <= 1'b0;
            commit_block_end_o   <= 1'b0;
            commit_ld_en_o       <= 1'b0;
            commit_st_en_o       <= 1'b0;
            commit_cnt_o         <= 1'b0;
            commit_ld_paddr_o    <= '0;
            commit_ld_vaddr_o    <= '0;
            commit_st_paddr_o    <= '0;
            commit_st_vaddr_o    <= '0;
            commit_timer_o       <= '0;
            ftq_id_o             <= '0;
        end else begin
            commit_valid_o       <= valid_i;
            commit_pc_o          <= pc_i;
            commit_instr_o       <= instr_i;
            commit_wdata_o       <= wdata_i;
            commit_st_data_o     <= store_data_i;
            commit_aluop_o       <= aluop_i;
            commit_we_o          <= wreg_i;
            commit_waddr_o       <= waddr_i;
            commit_llbit_we_o    <= mem_llbit_we_i;
            commit_llbit_value_o <= mem_llbit_value_i;
            commit_excp_o        <= excp_i;
            commit_excp_num_o    <= excp_num_i;
            commit_fetch_flush_o <= fetch_flush_i;
            commit_block_end_o   <= block_end_i;
            commit_ld_en_o       <= ld_en_i;
            commit_st_en_o       <= st_en_i;
            commit_cnt_o         <= cnt_inst_i;
            commit_ld_paddr_o    <= ld_paddr_i;
            commit_ld_vaddr_o    <= load_addr_i;
            commit_st_paddr_o    <= st_paddr_i;
            commit_st_vaddr_o    <= store_addr_i;
            commit_timer_o       <= timer_i;
            ftq_id_o             <= ftq_id_i;
        end
    end

endmodule

// File: verilog/wb_redirect.sv
module wb_redirect (
    input  logic                      valid_i,
    input  logic                      excp_i,
    input  logic                      need_refetch_i,
    input  logic                      is_last_in_block_i,
    input  logic [isa_pkg::REG_W-1:0] pc_i,

    output logic                      dcache_flush_o,
    output logic [isa_pkg::REG_W-1:0] dcache_flush_pc_o,
    output logic                      fetch_flush_o,
    output logic                      block_end_o
);

    logic valid_excp;

    assign valid_excp = valid_i && excp_i;

    // Dcache drops its pending state at the excepting pc
    assign dcache_flush_o    = valid_excp;
    assign dcache_flush_pc_o = pc_i;

    // Frontend restarts after a refetch or a trap
    assign fetch_flush_o = need_refetch_i || excp_i;

    // An exception always closes the basic block for the FTQ
    assign block_end_o = is_last_in_block_i || excp_i;

endmodule

// File: verilog/wb_mem_classify.sv
module wb_mem_classify (
    input  logic [isa_pkg::ALUOP_W-1:0]  aluop_i,

    input  logic                         llbit_i,
    input  logic                         llbit_we_i,
    input  logic                         llbit_value_i,

    input  logic [mem_pkg::VADDR_W-1:0]  load_addr_i,
    input  logic [mem_pkg::VADDR_W-1:0]  store_addr_i,
    input  logic [mem_pkg::PTAG_W-1:0]   tlb_tag_i,

    output logic                         ld_en_o,
    output logic                         st_en_o,
    output logic                         cnt_inst_o,
    output logic [mem_pkg::VADDR_W-1:0]  ld_paddr_o,
    output logic [mem_pkg::VADDR_W-1:0]  st_paddr_o
);
    import isa_pkg::*;
    import mem_pkg::*;

    logic             llbit;
    logic             sc_ok;
    logic [CLS_W-1:0] op_class;
    mem_addr_u        ld_addr;
    mem_addr_u        st_addr;

    // CSR write in the same cycle wins over the stored bit
    assign llbit = llbit_we_i ? llbit_value_i : llbit_i;

    assign sc_ok = (aluop_i == OP_SC) && llbit;

    always_comb begin
        case (aluop_i)
            OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL: begin
                op_class = CLS_LOAD;
            end
            OP_ST_B, OP_ST_H, OP_ST_W: begin
                op_class = CLS_STORE;
            end
            // Failed SC touches no memory at all
            OP_SC: begin
                op_class = sc_ok ? CLS_STORE : CLS_NONE;
            end
            OP_RDCNTVL, OP_RDCNTVH, OP_RDCNTID: begin
                op_class = CLS_CNT;
            end
            default: begin
                op_class = CLS_NONE;
            end
        endcase
    end

    assign ld_en_o    = (op_class == CLS_LOAD);
    assign st_en_o    = (op_class == CLS_STORE);
    assign cnt_inst_o = (op_class == CLS_CNT);

    // Page offset kept, page number swapped for the TLB tag
    assign ld_addr.raw = load_addr_i;
    assign st_addr.raw = store_addr_i;

    assign ld_paddr_o = {tlb_tag_i, ld_addr.page.ofs};
    assign st_paddr_o = {tlb_tag_i, st_addr.page.ofs};

endmodule

// File: verilog/mem_pkg.sv
package mem_pkg;

    // Virtual address space
    localparam int VADDR_W    = 32;
    localparam int PAGE_OFS_W = 12;

    // Page number part of a virtual address
    localparam int VPN_W      = VADDR_W - PAGE_OFS_W;

    // Physical page tag returned by the data TLB lookup
    localparam int PTAG_W     = 20;

    // One address word, seen either whole or split at the 4 KiB page boundary.
    // The TLB tag replaces vpn when a physical address is built.
    typedef union packed {
        logic [VADDR_W-1:0] raw;
        struct packed {
            logic [VPN_W-1:0]      vpn;
            logic [PAGE_OFS_W-1:0] ofs;
        } page;
    } mem_addr_u;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

    // Register file and datapath widths
    localparam int REG_W      = 32;
    localparam int RADDR_W    = 5;

    localparam int ALUOP_W    = 8;
    localparam int EXCP_NUM_W = 16;
    localparam int FTQ_ID_W   = 3;

    // Stable counter carried to difftest
    localparam int TIMER_W    = 64;

    // Loads, LL included
    localparam logic [ALUOP_W-1:0] OP_LD_B    = 8'h20;
    localparam logic [ALUOP_W-1:0] OP_LD_BU   = 8'h21;
    localparam logic [ALUOP_W-1:0] OP_LD_H    = 8'h22;
    localparam logic [ALUOP_W-1:0] OP_LD_HU   = 8'h23;
    localparam logic [ALUOP_W-1:0] OP_LD_W    = 8'h24;
    localparam logic [ALUOP_W-1:0] OP_LL      = 8'h25;

    // Stores
    localparam logic [ALUOP_W-1:0] OP_ST_B    = 8'h28;
    localparam logic [ALUOP_W-1:0] OP_ST_H    = 8'h29;
    localparam logic [ALUOP_W-1:0] OP_ST_W    = 8'h2a;
    // SC only stores when the LL bit survives
    localparam logic [ALUOP_W-1:0] OP_SC      = 8'h2b;

    // Counter reads
    localparam logic [ALUOP_W-1:0] OP_RDCNTVL = 8'h30;
    localparam logic [ALUOP_W-1:0] OP_RDCNTVH = 8'h31;
    localparam logic [ALUOP_W-1:0] OP_RDCNTID = 8'h32;

    // Op classes seen by the writeback stage
    localparam int CLS_W = 2;

    localparam logic [CLS_W-1:0] CLS_NONE  = 2'd0;
    localparam logic [CLS_W-1:0] CLS_LOAD  = 2'd1;
    localparam logic [CLS_W-1:0] CLS_STORE = 2'd2;
    localparam logic [CLS_W-1:0] CLS_CNT   = 2'd3;

endpackage
